//--- common/apb_if.sv
/*
 * APB interface between the decoder and one peer
 */
`timescale 1ns/10ps

interface apb_if import periph_pkg::*; ();

    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [RegionLsb-1:0]    paddr;   // Offset within the region
    logic [ApbDataWidth-1:0] pwdata;
    logic [ApbDataWidth-1:0] prdata;
    logic                    pready;
    logic                    pslverr;

    modport master (
        output psel, penable, pwrite, paddr, pwdata,
        input  prdata, pready, pslverr
    );

    modport slave (
        input  psel, penable, pwrite, paddr, pwdata,
        output prdata, pready, pslverr
    );

endinterface

//--- common/periph_pkg.sv
/*
 * Shared widths, address map and register offsets of the peripheral subsystem
 * Enums for regions, UART registers and UART shifter states
 */
package periph_pkg;

    // APB bus
    parameter int ApbAddrWidth = 12;
    parameter int ApbDataWidth = 32;

    // Region field of the address, word offset below it
    parameter int RegionMsb = 11;
    parameter int RegionLsb = 8;
    parameter int WordWidth = RegionLsb - 2;

    typedef enum logic [RegionMsb-RegionLsb:0] {
        REGION_PLIC  = 4'd0,
        REGION_UART  = 4'd1,
        REGION_TIMER = 4'd2
    } region_e;

    parameter logic [ApbDataWidth-1:0] ErrFill = 32'hDEADBEEF;

    // --------------------------------------------------------------------------
    // UART
    // --------------------------------------------------------------------------
    typedef enum logic [WordWidth-1:0] {
        UART_TXDATA  = 6'd0,
        UART_RXDATA  = 6'd1,
        UART_STATUS  = 6'd2,
        UART_DIVISOR = 6'd3
    } uart_reg_e;

    typedef enum logic [1:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_STOP
    } uart_state_e;

    parameter logic [15:0] UartDivReset = 16'd16; // Clocks per bit

    // --------------------------------------------------------------------------
    // PLIC and timers
    // --------------------------------------------------------------------------
    parameter int PrioWidth      = 3;
    parameter int PlicPrioBase   = 0;  // Source n at word n
    parameter int PlicPending    = 15;
    parameter int PlicTargetBase = 16; // Enable, threshold, claim per target

    parameter int TimerStatus    = 31;

endpackage

//--- logic/apb_decoder.sv
/*
 * APB region decoder for PLIC, UART and timers
 * Unmapped regions answer with an error and a filler word
 */
`timescale 1ns/10ps

module apb_decoder import periph_pkg::*; (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    psel_i,
    input  logic                    penable_i,
    input  logic                    pwrite_i,
    input  logic [ApbAddrWidth-1:0] paddr_i,
    input  logic [ApbDataWidth-1:0] pwdata_i,
    output logic [ApbDataWidth-1:0] prdata_o,
    output logic                    pready_o,
    output logic                    pslverr_o,
    apb_if.master                   plic_o,
    apb_if.master                   uart_o,
    apb_if.master                   timer_o
);

    region_e region;
    logic    access;

    assign region = region_e'(paddr_i[RegionMsb:RegionLsb]);
    assign access = psel_i & penable_i;

    // Request side is shared, only psel is steered
    assign plic_o.penable  = penable_i;
    assign plic_o.pwrite   = pwrite_i;
    assign plic_o.paddr    = paddr_i[RegionLsb-1:0];
    assign plic_o.pwdata   = pwdata_i;
    assign uart_o.penable  = penable_i;
    assign uart_o.pwrite   = pwrite_i;
    assign uart_o.paddr    = paddr_i[RegionLsb-1:0];
    assign uart_o.pwdata   = pwdata_i;
    assign timer_o.penable = penable_i;
    assign timer_o.pwrite  = pwrite_i;
    assign timer_o.paddr   = paddr_i[RegionLsb-1:0];
    assign timer_o.pwdata  = pwdata_i;

    always_comb begin
        plic_o.psel  = 1'b0;
        uart_o.psel  = 1'b0;
        timer_o.psel = 1'b0;
        prdata_o     = ErrFill;   // Unmapped answer
        pready_o     = access;
        pslverr_o    = access;
        case (region)
            REGION_PLIC: begin
                plic_o.psel = psel_i;
                prdata_o    = plic_o.prdata;
                pready_o    = plic_o.pready;
                pslverr_o   = plic_o.pslverr;
            end
            REGION_UART: begin
                uart_o.psel = psel_i;
                prdata_o    = uart_o.prdata;
                pready_o    = uart_o.pready;
                pslverr_o   = uart_o.pslverr;
            end
            REGION_TIMER: begin
                timer_o.psel = psel_i;
                prdata_o     = timer_o.prdata;
                pready_o     = timer_o.pready;
                pslverr_o    = timer_o.pslverr;
            end
            default: ;
        endcase
    end

endmodule

//--- logic/soc_peripherals.sv
/*
 * Peripheral subsystem top level
 * APB decoder with UART, compare timers and PLIC as peers
 */
`timescale 1ns/10ps

module soc_peripherals import periph_pkg::*; #(
    parameter int NumTimers  = 2,
    parameter int NumTargets = 2
) (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    psel_i,
    input  logic                    penable_i,
    input  logic                    pwrite_i,
    input  logic [ApbAddrWidth-1:0] paddr_i,
    input  logic [ApbDataWidth-1:0] pwdata_i,
    output logic [ApbDataWidth-1:0] prdata_o,
    output logic                    pready_o,
    output logic                    pslverr_o,
    output logic [NumTargets-1:0]   irq_o,
    input  logic                    rx_i,
    output logic                    tx_o
);

    localparam int NumSources = NumTimers + 1;

    logic                 rx_valid;
    logic [NumTimers-1:0] timer_pending;
    logic [NumSources:1]  irq_sources;

    apb_if plic_bus ();
    apb_if uart_bus ();
    apb_if timer_bus ();

    // Source 1 is the UART receiver, timers follow
    assign irq_sources = {timer_pending, rx_valid};

    apb_decoder i_apb_decoder (
        .clk_i     ( clk_i     ),
        .rst_i     ( rst_i     ),
        .psel_i    ( psel_i    ),
        .penable_i ( penable_i ),
        .pwrite_i  ( pwrite_i  ),
        .paddr_i   ( paddr_i   ),
        .pwdata_i  ( pwdata_i  ),
        .prdata_o  ( prdata_o  ),
        .pready_o  ( pready_o  ),
        .pslverr_o ( pslverr_o ),
        .plic_o    ( plic_bus  ),
        .uart_o    ( uart_bus  ),
        .timer_o   ( timer_bus )
    );

    uart_core i_uart (
        .clk_i      ( clk_i    ),
        .rst_i      ( rst_i    ),
        .bus_i      ( uart_bus ),
        .rx_i       ( rx_i     ),
        .tx_o       ( tx_o     ),
        .rx_valid_o ( rx_valid )
    );

    timer_bank #(
        .NumTimers ( NumTimers )
    ) i_timer (
        .clk_i     ( clk_i         ),
        .rst_i     ( rst_i         ),
        .bus_i     ( timer_bus     ),
        .pending_o ( timer_pending )
    );

    plic_core #(
        .NumSources ( NumSources ),
        .NumTargets ( NumTargets )
    ) i_plic (
        .clk_i     ( clk_i       ),
        .rst_i     ( rst_i       ),
        .bus_i     ( plic_bus    ),
        .sources_i ( irq_sources ),
        .irq_o     ( irq_o       )
    );

endmodule

//--- plic/plic_core.sv
/*
 * Level-triggered PLIC with per-target enables and thresholds
 * Claim returns the best pending source, complete releases it
 */
`timescale 1ns/10ps

module plic_core import periph_pkg::*; #(
    parameter int NumSources = 3,
    parameter int NumTargets = 2
) (
    input  logic                  clk_i,
    input  logic                  rst_i,
    apb_if.slave                  bus_i,
    input  logic [NumSources:1]   sources_i,
    output logic [NumTargets-1:0] irq_o
);

    localparam int IdWidth = $clog2(NumSources + 1);

    logic [WordWidth-1:0] word;
    logic                 wr;
    logic                 rd;
    logic [PrioWidth-1:0] prio [1:NumSources];
    logic [NumSources:1]  pending;
    logic [NumSources:1]  in_service;
    logic [NumSources:1]  enable [NumTargets];
    logic [PrioWidth-1:0] threshold [NumTargets];
    logic [IdWidth-1:0]   claim_id [NumTargets];
    logic [NumSources:1]  claim_mask;
    logic [NumSources:1]  complete_mask;

    assign word = bus_i.paddr[RegionLsb-1:2];
    assign wr   = bus_i.psel & bus_i.penable & bus_i.pwrite;
    assign rd   = bus_i.psel & bus_i.penable & ~bus_i.pwrite;

    assign bus_i.pready  = bus_i.psel & bus_i.penable;
    assign bus_i.pslverr = 1'b0;

    // Highest priority above threshold, lowest id on a tie
    always_comb begin
        logic [PrioWidth-1:0] best_prio;
        for (int t = 0; t < NumTargets; t++) begin
            best_prio   = '0;
            claim_id[t] = '0;
            for (int s = NumSources; s >= 1; s--) begin
                if (pending[s] && enable[t][s] && prio[s] > threshold[t] &&
                    prio[s] >= best_prio) begin
                    best_prio   = prio[s];
                    claim_id[t] = IdWidth'(s);
                end
            end
        end
    end

    always_comb begin
        claim_mask    = '0;
        complete_mask = '0;
        for (int t = 0; t < NumTargets; t++) begin
            for (int s = 1; s <= NumSources; s++) begin
                if (word == PlicTargetBase + 4 * t + 2) begin
                    if (rd && claim_id[t] == IdWidth'(s)) claim_mask[s] = 1'b1;
                    if (wr && bus_i.pwdata == s) complete_mask[s] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pending    <= '0;
            in_service <= '0;
            irq_o      <= '0;
            for (int s = 1; s <= NumSources; s++) prio[s] <= '0;
            for (int t = 0; t < NumTargets; t++) begin
                enable[t]    <= '0;
                threshold[t] <= '0;
            end
        end else begin
            // Gateways
            pending    <= (pending | (sources_i & ~in_service)) & ~claim_mask;
            in_service <= (in_service | claim_mask) & ~complete_mask;
            for (int s = 1; s <= NumSources; s++) begin
                if (wr && word == PlicPrioBase + s) prio[s] <= bus_i.pwdata[PrioWidth-1:0];
            end
            for (int t = 0; t < NumTargets; t++) begin
                irq_o[t] <= (claim_id[t] != '0);
                if (wr && word == PlicTargetBase + 4 * t) begin
                    enable[t] <= bus_i.pwdata[NumSources:1];
                end
                if (wr && word == PlicTargetBase + 4 * t + 1) begin
                    threshold[t] <= bus_i.pwdata[PrioWidth-1:0];
                end
            end
        end
    end

    always_comb begin
        bus_i.prdata = '0;
        if (word == PlicPending) bus_i.prdata[NumSources:0] = {pending, 1'b0};
        for (int s = 1; s <= NumSources; s++) begin
            if (word == PlicPrioBase + s) bus_i.prdata[PrioWidth-1:0] = prio[s];
        end
        for (int t = 0; t < NumTargets; t++) begin
            if (word == PlicTargetBase + 4 * t) bus_i.prdata[NumSources:0] = {enable[t], 1'b0};
            if (word == PlicTargetBase + 4 * t + 1) bus_i.prdata[PrioWidth-1:0] = threshold[t];
            if (word == PlicTargetBase + 4 * t + 2) bus_i.prdata[IdWidth-1:0] = claim_id[t];
        end
    end

endmodule

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" &&
verilator --binary -Wno-fatal -f tb.f --top-module soc_peripherals_tb -o soc_peripherals_sim &&
./obj_dir/soc_peripherals_sim | tee /dev/stderr | grep -q "Everything OK" &&
echo "PASS" || { echo "FAIL"; exit 1; }

//--- tb.f
common/periph_pkg.sv
common/apb_if.sv
logic/apb_decoder.sv
uart/uart_core.sv
timer/timer_bank.sv
plic/plic_core.sv
logic/soc_peripherals.sv
verification/soc_peripherals_tb.sv

//--- timer/timer_bank.sv
/*
 * Bank of compare timers with sticky pending bits
 */
`timescale 1ns/10ps

module timer_bank import periph_pkg::*; #(
    parameter int NumTimers = 2
) (
    input  logic                 clk_i,
    input  logic                 rst_i,
    apb_if.slave                 bus_i,
    output logic [NumTimers-1:0] pending_o
);

    logic [WordWidth-1:0] word;
    logic [WordWidth-3:0] idx;
    logic [1:0]           sub;
    logic                 wr;
    logic [31:0]          count   [NumTimers];
    logic [31:0]          compare [NumTimers];
    logic [NumTimers-1:0] enable;
    logic [NumTimers-1:0] hit;
    logic [NumTimers-1:0] clear;

    assign word = bus_i.paddr[RegionLsb-1:2];
    assign idx  = word[WordWidth-1:2];   // Timer number
    assign sub  = word[1:0];             // Count, compare, control
    assign wr   = bus_i.psel & bus_i.penable & bus_i.pwrite;

    assign bus_i.pready  = bus_i.psel & bus_i.penable;
    assign bus_i.pslverr = 1'b0;

    always_comb begin
        for (int i = 0; i < NumTimers; i++) begin
            hit[i] = enable[i] && count[i] == compare[i];
        end
        clear = (wr && word == TimerStatus) ? bus_i.pwdata[NumTimers-1:0] : '0;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            enable    <= '0;
            pending_o <= '0;
            for (int i = 0; i < NumTimers; i++) begin
                count[i]   <= '0;
                compare[i] <= '0;
            end
        end else begin
            pending_o <= (pending_o & ~clear) | hit; // A new match wins over clear
            for (int i = 0; i < NumTimers; i++) begin
                if (hit[i]) begin
                    count[i] <= '0;
                end else if (enable[i]) begin
                    count[i] <= count[i] + 32'd1;
                end
                if (wr && int'(idx) == i) begin
                    case (sub)
                        2'd0: count[i]   <= bus_i.pwdata;
                        2'd1: compare[i] <= bus_i.pwdata;
                        2'd2: enable[i]  <= bus_i.pwdata[0];
                        default: ;
                    endcase
                end
            end
        end
    end

    always_comb begin
        bus_i.prdata = '0;
        if (word == TimerStatus) begin
            bus_i.prdata[NumTimers-1:0] = pending_o;
        end else begin
            for (int i = 0; i < NumTimers; i++) begin
                if (int'(idx) == i) begin
                    case (sub)
                        2'd0: bus_i.prdata    = count[i];
                        2'd1: bus_i.prdata    = compare[i];
                        2'd2: bus_i.prdata[0] = enable[i];
                        default: ;
                    endcase
                end
            end
        end
    end

endmodule

//--- uart/uart_core.sv
/*
 * UART with APB registers, 8N1 frames, LSB first
 * Programmable baud divisor, receiver samples at mid-bit
 */
`timescale 1ns/10ps

module uart_core import periph_pkg::*; (
    input  logic clk_i,
    input  logic rst_i,
    apb_if.slave bus_i,
    input  logic rx_i,
    output logic tx_o,
    output logic rx_valid_o
);

    logic [WordWidth-1:0] word;
    logic                 wr;
    logic                 rd;
    logic [15:0]          divisor;
    uart_state_e          tx_state;
    logic [15:0]          tx_cnt;
    logic [2:0]           tx_bit;
    logic [7:0]           tx_shift;
    logic                 tx_busy;
    logic                 tx_start;
    logic                 tx_tick;
    uart_state_e          rx_state;
    logic [15:0]          rx_cnt;
    logic [2:0]           rx_bit;
    logic [7:0]           rx_shift;
    logic [7:0]           rx_data;
    logic [1:0]           rx_sync;
    logic                 rx_tick;
    logic                 rx_mid;

    assign word = bus_i.paddr[RegionLsb-1:2];
    assign wr   = bus_i.psel & bus_i.penable & bus_i.pwrite;
    assign rd   = bus_i.psel & bus_i.penable & ~bus_i.pwrite;

    assign bus_i.pready  = bus_i.psel & bus_i.penable;
    assign bus_i.pslverr = 1'b0;

    always_comb begin
        bus_i.prdata = '0;
        case (uart_reg_e'(word))
            UART_RXDATA:  bus_i.prdata[7:0]  = rx_data;
            UART_STATUS:  bus_i.prdata[1:0]  = {rx_valid_o, tx_busy};
            UART_DIVISOR: bus_i.prdata[15:0] = divisor;
            default: ;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            divisor <= UartDivReset;
        end else if (wr && word == UART_DIVISOR) begin
            divisor <= bus_i.pwdata[15:0];
        end
    end

    // --------------------------------------------------------------------------
    // Transmitter
    // --------------------------------------------------------------------------
    assign tx_busy  = (tx_state != UART_IDLE);
    assign tx_start = wr && word == UART_TXDATA && !tx_busy; // Dropped while busy
    assign tx_tick  = (tx_cnt == divisor - 16'd1);
    assign tx_o     = (tx_state == UART_START) ? 1'b0 :
                      (tx_state == UART_DATA)  ? tx_shift[0] : 1'b1;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            tx_state <= UART_IDLE;
            tx_cnt   <= '0;
            tx_bit   <= '0;
        end else if (!tx_busy) begin
            tx_cnt <= '0;
            tx_bit <= '0;
            if (tx_start) tx_state <= UART_START;
        end else if (tx_tick) begin
            tx_cnt <= '0;
            case (tx_state)
                UART_START: tx_state <= UART_DATA;
                UART_DATA: begin
                    tx_bit <= tx_bit + 3'd1;
                    if (tx_bit == 3'd7) tx_state <= UART_STOP;
                end
                default: tx_state <= UART_IDLE;  // End of stop bit
            endcase
        end else begin
            tx_cnt <= tx_cnt + 16'd1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (tx_start) begin
            tx_shift <= bus_i.pwdata[7:0];
        end else if (tx_state == UART_DATA && tx_tick) begin
            tx_shift <= tx_shift >> 1;
        end
    end

    // --------------------------------------------------------------------------
    // Receiver
    // --------------------------------------------------------------------------
    assign rx_tick = (rx_cnt == divisor - 16'd1);
    assign rx_mid  = (rx_cnt == (divisor >> 1) - 16'd1);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rx_sync    <= 2'b11;
            rx_state   <= UART_IDLE;
            rx_cnt     <= '0;
            rx_bit     <= '0;
            rx_valid_o <= 1'b0;
        end else begin
            rx_sync <= {rx_sync[0], rx_i};
            rx_cnt  <= rx_cnt + 16'd1;
            if (rd && word == UART_RXDATA) rx_valid_o <= 1'b0;
            case (rx_state)
                UART_IDLE: begin
                    rx_cnt <= '0;
                    if (!rx_sync[1]) rx_state <= UART_START;
                end
                UART_START: if (rx_mid) begin
                    rx_cnt   <= '0;
                    rx_bit   <= '0;
                    rx_state <= rx_sync[1] ? UART_IDLE : UART_DATA; // Glitch rejected
                end
                UART_DATA: if (rx_tick) begin
                    rx_cnt <= '0;
                    rx_bit <= rx_bit + 3'd1;
                    if (rx_bit == 3'd7) rx_state <= UART_STOP;
                end
                default: if (rx_tick) begin
                    rx_state <= UART_IDLE;
                    if (rx_sync[1]) rx_valid_o <= 1'b1;  // Good stop bit
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (rx_state == UART_DATA && rx_tick) rx_shift <= {rx_sync[1], rx_shift[7:1]};
        if (rx_state == UART_STOP && rx_tick && rx_sync[1]) rx_data <= rx_shift;
    end

endmodule

//--- verification/soc_peripherals_tb.sv
/*
 * Testbench for the peripheral subsystem
 * APB driver tasks, LFSR stimulus, register model of PLIC and timers
 */
`timescale 1ns/10ps

module soc_peripherals_tb;

    localparam int          NumTimers  = 2;
    localparam int          NumTargets = 2;
    localparam int          NumSources = NumTimers + 1;
    localparam logic [31:0] LfsrTaps   = 32'h80200003;
    localparam logic [31:0] EnableMask = ((32'd1 << NumSources) - 1) << 1;

    // Address map
    localparam int RegionPlic  = 0;
    localparam int RegionUart  = 1;
    localparam int RegionTimer = 2;
    localparam int UartTx      = 0;
    localparam int UartRx      = 1;
    localparam int UartStatus  = 2;
    localparam int UartDiv     = 3;
    localparam int PlicPend    = 15;
    localparam int TimerStat   = 31;

    logic                  clk;
    logic                  rst;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [11:0]           paddr;
    logic [31:0]           pwdata;
    logic [31:0]           prdata;
    logic                  pready;
    logic                  pslverr;
    logic [NumTargets-1:0] irq;
    logic                  serial;   // tx looped back to rx

    logic [31:0] lfsr_state;
    logic [31:0] m_divisor;
    logic [2:0]  m_prio      [NumSources+1];
    logic [31:0] m_enable    [NumTargets];
    logic [2:0]  m_threshold [NumTargets];
    logic [31:0] m_pending;     // Bit s is source s
    logic [31:0] m_in_service;
    logic [31:0] m_timer_pend;
    logic        m_rx_valid;

    soc_peripherals #(
        .NumTimers  ( NumTimers  ),
        .NumTargets ( NumTargets )
    ) soc_peripherals_inst (
        .clk_i     ( clk     ),
        .rst_i     ( rst     ),
        .psel_i    ( psel    ),
        .penable_i ( penable ),
        .pwrite_i  ( pwrite  ),
        .paddr_i   ( paddr   ),
        .pwdata_i  ( pwdata  ),
        .prdata_o  ( prdata  ),
        .pready_o  ( pready  ),
        .pslverr_o ( pslverr ),
        .irq_o     ( irq     ),
        .rx_i      ( serial  ),
        .tx_o      ( serial  )
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ LfsrTaps) : (state >> 1);
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val        = {val[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return val;
    endfunction

    function automatic logic [11:0] reg_addr(input int region, input int word);
        return 12'((region << 8) + (word << 2));
    endfunction

    function automatic logic unmapped(input logic [11:0] addr);
        return addr[11:8] > 4'd2;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            report_failure($sformatf("error %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic apb_transfer(input logic write, input logic [11:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata);
        @(posedge clk);
        #2;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        check_value("pready in setup", 32'd0, pready);
        @(posedge clk);
        #2;
        penable = 1'b1;
        @(negedge clk);
        check_value("pready in access", 32'd1, pready);
        check_value("pslverr", unmapped(addr), pslverr);
        rdata = prdata;
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        apb_transfer(1'b1, addr, data, unused);
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data);
        apb_transfer(1'b0, addr, '0, data);
    endtask

    task automatic read_check(input string name, input logic [11:0] addr,
                              input logic [31:0] expected);
        logic [31:0] data;
        apb_read(addr, data);
        check_value(name, expected, data);
    endtask

    // Poll a register until the masked bits match
    task automatic wait_bits(input logic [11:0] addr, input logic [31:0] mask,
                             input logic [31:0] value, input string what);
        logic [31:0] data;
        int          polls;
        polls = 0;
        apb_read(addr, data);
        while ((data & mask) != value) begin
            polls++;
            if (polls > 400) report_failure({"timeout waiting for ", what});
            apb_read(addr, data);
        end
    endtask

    // ------------------------------------------------------------------------
    // PLIC model
    // ------------------------------------------------------------------------
    function automatic logic [31:0] source_levels();
        return (m_timer_pend << 2) | (32'(m_rx_valid) << 1);
    endfunction

    task automatic update_gateways();
        m_pending = m_pending | (source_levels() & ~m_in_service);
    endtask

    function automatic int model_claim(input int t);
        int id;
        id = 0;
        for (int s = 1; s <= NumSources; s++) begin
            if (m_pending[s] && m_enable[t][s] && m_prio[s] > m_threshold[t]) begin
                if (id == 0 || m_prio[s] > m_prio[id]) id = s;   // Lowest id keeps ties
            end
        end
        return id;
    endfunction

    function automatic logic [NumTargets-1:0] model_irq();
        logic [NumTargets-1:0] val;
        for (int t = 0; t < NumTargets; t++) val[t] = (model_claim(t) != 0);
        return val;
    endfunction

    task automatic wait_irq();
        int cycles;
        cycles = 0;
        while (irq !== model_irq()) begin
            cycles++;
            if (cycles > 20) begin
                report_failure($sformatf("timeout waiting for irq_o to become %b, still %b",
                                         model_irq(), irq));
            end
            @(negedge clk);
        end
    endtask

    task automatic configure_plic();
        logic [31:0] value;
        for (int s = 1; s <= NumSources; s++) begin
            value = random_bits(32);
            apb_write(reg_addr(RegionPlic, s), value);
            m_prio[s] = value[2:0];
            read_check("priority", reg_addr(RegionPlic, s), 32'(m_prio[s]));
        end
        for (int t = 0; t < NumTargets; t++) begin
            value = random_bits(32);
            apb_write(reg_addr(RegionPlic, 16 + 4 * t), value);
            m_enable[t] = value & EnableMask;
            read_check("enable", reg_addr(RegionPlic, 16 + 4 * t), m_enable[t]);
            value = random_bits(32);
            apb_write(reg_addr(RegionPlic, 17 + 4 * t), value);
            m_threshold[t] = value[2:0];
            read_check("threshold", reg_addr(RegionPlic, 17 + 4 * t), 32'(m_threshold[t]));
        end
    endtask

    // Runs timer i until its pending bit is seen, then stops it
    task automatic fire_timer(input int i, input logic [31:0] compare);
        apb_write(reg_addr(RegionTimer, 4 * i + 1), compare);
        apb_write(reg_addr(RegionTimer, 4 * i), 32'd0);
        apb_write(reg_addr(RegionTimer, 4 * i + 2), 32'd1);
        wait_bits(reg_addr(RegionTimer, TimerStat), 32'd1 << i, 32'd1 << i,
                  $sformatf("timer %0d pending bit", i));
        m_timer_pend[i] = 1'b1;
        update_gateways();
        apb_write(reg_addr(RegionTimer, 4 * i + 2), 32'd0);
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        logic [31:0]          data;
        logic [31:0]          value;
        logic [7:0]           first_byte;
        logic [NumTimers-1:0] active;
        int                   region;
        int                   id;
        lfsr_state   = 32'd34;
        rst          = 1'b1;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        m_pending    = '0;
        m_in_service = '0;
        m_timer_pend = '0;
        m_rx_valid   = 1'b0;
        for (int s = 0; s <= NumSources; s++) m_prio[s] = '0;
        for (int t = 0; t < NumTargets; t++) begin
            m_enable[t]    = '0;
            m_threshold[t] = '0;
        end
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;

        // Register access
        m_divisor = random_bits(16);
        apb_write(reg_addr(RegionUart, UartDiv), m_divisor);
        read_check("divisor", reg_addr(RegionUart, UartDiv), m_divisor);
        for (int i = 0; i < NumTimers; i++) begin
            value = random_bits(32);
            apb_write(reg_addr(RegionTimer, 4 * i + 1), value);
            read_check("timer compare", reg_addr(RegionTimer, 4 * i + 1), value);
        end
        configure_plic();

        // Unmapped regions
        region = 3 + int'(random_bits(4) % 13);
        apb_read(reg_addr(region, int'(random_bits(6))), data);
        check_value("unmapped read", 32'hDEADBEEF, data);
        apb_write(reg_addr(region, UartDiv), random_bits(32));
        read_check("divisor after unmapped write", reg_addr(RegionUart, UartDiv), m_divisor);
        read_check("priority after unmapped write", reg_addr(RegionPlic, 3), 32'(m_prio[3]));

        // UART loopback
        m_divisor = 4 + random_bits(4) % 13;
        apb_write(reg_addr(RegionUart, UartDiv), m_divisor);
        first_byte = 8'(random_bits(8));
        apb_write(reg_addr(RegionUart, UartTx), first_byte);
        read_check("tx_busy after TXDATA write", reg_addr(RegionUart, UartStatus), 32'h1);
        apb_write(reg_addr(RegionUart, UartTx), random_bits(8));   // Dropped while busy
        wait_bits(reg_addr(RegionUart, UartStatus), 32'h2, 32'h2, "rx_valid after the frame");
        m_rx_valid = 1'b1;
        update_gateways();
        read_check("pending with rx_valid", reg_addr(RegionPlic, PlicPend), m_pending);
        read_check("received byte", reg_addr(RegionUart, UartRx), first_byte);
        m_rx_valid = 1'b0;
        apb_read(reg_addr(RegionUart, UartStatus), data);
        check_value("rx_valid after RXDATA read", 32'd0, data[1]);
        wait_bits(reg_addr(RegionUart, UartStatus), 32'h1, 32'h0, "tx_busy to fall");
        for (int i = 0; i < 4 * m_divisor; i++) begin
            read_check("status after single frame", reg_addr(RegionUart, UartStatus), 32'h0);
        end

        // Timers
        for (int i = 0; i < NumTimers; i++) begin
            fire_timer(i, 5 + random_bits(6));
            apb_write(reg_addr(RegionTimer, TimerStat), 32'd1 << i);
            m_timer_pend[i] = 1'b0;
            read_check("timer status after clear", reg_addr(RegionTimer, TimerStat), m_timer_pend);
            apb_read(reg_addr(RegionTimer, 4 * i), data);
            read_check("disabled timer count", reg_addr(RegionTimer, 4 * i), data);
        end
        read_check("pending after timers", reg_addr(RegionPlic, PlicPend), m_pending);

        // PLIC arbitration
        // Timers left pending keep their sources high
        active = NumTimers'(random_bits(NumTimers));
        if (active == '0) active = 1;
        for (int i = 0; i < NumTimers; i++) begin
            if (active[i]) fire_timer(i, 5 + random_bits(4));
        end
        for (int r = 0; r < 6; r++) begin
            configure_plic();
            wait_irq();
            for (int t = 0; t < NumTargets; t++) begin
                id = model_claim(t);
                read_check("claim id", reg_addr(RegionPlic, 18 + 4 * t), id);
                if (id != 0) begin
                    m_pending[id]    = 1'b0;
                    m_in_service[id] = 1'b1;
                    read_check("pending after claim", reg_addr(RegionPlic, PlicPend), m_pending);
                    apb_write(reg_addr(RegionPlic, 18 + 4 * t), id);
                    m_in_service[id] = 1'b0;
                    update_gateways();
                    read_check("pending after complete", reg_addr(RegionPlic, PlicPend),
                               m_pending);
                end
                wait_irq();
            end
        end

        $display("Everything OK");
        $finish;
    end

endmodule
